// ==== mp_params.svh ====
`ifndef MP_PARAMS_SVH
`define MP_PARAMS_SVH

// Data path and bank geometry
`define MP_DATA_W 32
`define MP_BANK_W 3                // Low address bits pick the bank
`define MP_ROW_W 6
`define MP_ADDR_W (`MP_BANK_W + `MP_ROW_W)
`define MP_NUM_BANKS (1 << `MP_BANK_W)
`define MP_NUM_ROWS (1 << `MP_ROW_W)

// Refresh scheduling
`define MP_REFR_MAX_PEND 4
`define MP_REFR_WAIT 3             // Cycles a blocked refresh waits before it is forced

// Counter widths that must hold the limits above
`define MP_PEND_W 3
`define MP_WAIT_W 2

`endif

// ==== mp_pkg.sv ====
`include "mp_params.svh"

package mp_pkg;

  // Port address is row in the high bits, bank in the low bits
  typedef logic [`MP_DATA_W-1:0] data_t;
  typedef logic [`MP_ADDR_W-1:0] addr_t;
  typedef logic [`MP_BANK_W-1:0] bank_t;
  typedef logic [`MP_ROW_W-1:0]  row_t;

  typedef logic [`MP_PEND_W-1:0] pend_t;

  typedef enum logic [1:0] {
    REFR_IDLE,
    REFR_WAIT,
    REFR_FORCE
  } refr_state_t;

endpackage

// ==== bank_ram.sv ====
`timescale 1ns/1ps
`include "mp_params.svh"

module bank_ram (
  input  logic          clk,
  input  logic          en,
  input  logic          we,
  input  mp_pkg::row_t  row,
  input  mp_pkg::data_t din,
  input  logic          refresh,
  output mp_pkg::data_t dout
);
  import mp_pkg::*;

  data_t mem [0:`MP_NUM_ROWS-1];

  // A refresh cycle occupies the bank, so dout and the contents stay as they are
  always_ff @(posedge clk) begin
    if (en && !refresh) begin
      if (we) begin
        mem[row] <= din;
      end else begin
        dout <= mem[row];
      end
    end
  end

  // The arbiter must keep refresh and port accesses apart on every bank
  a_refr_excl: assert property (@(posedge clk) en |-> !refresh)
    else $error("bank_ram: access and refresh in the same cycle");

endmodule

// ==== bank_array.sv ====
`timescale 1ns/1ps
`include "mp_params.svh"

module bank_array (
  input  logic          clk,
  input  logic [1:0]    grant,
  input  logic          refr_grant,
  input  mp_pkg::bank_t refr_bank,
  input  logic          p0_we,
  input  mp_pkg::addr_t p0_adr,
  input  mp_pkg::data_t p0_dat_w,
  input  logic          p1_we,
  input  mp_pkg::addr_t p1_adr,
  input  mp_pkg::data_t p1_dat_w,
  output mp_pkg::data_t p0_dat_r,
  output mp_pkg::data_t p1_dat_r
);
  import mp_pkg::*;

  bank_t bank0;
  bank_t bank1;
  row_t  row0;
  row_t  row1;
  bank_t sel0;
  bank_t sel1;
  data_t bank_dout [`MP_NUM_BANKS];

  assign bank0 = p0_adr[`MP_BANK_W-1:0];
  assign bank1 = p1_adr[`MP_BANK_W-1:0];
  assign row0  = p0_adr[`MP_ADDR_W-1:`MP_BANK_W];
  assign row1  = p1_adr[`MP_ADDR_W-1:`MP_BANK_W];

  for (genvar b = 0; b < `MP_NUM_BANKS; b++) begin : g_bank
    logic hit0;
    logic hit1;
    logic refr_hit;

    assign hit0     = grant[0] && (bank0 == bank_t'(b));
    assign hit1     = grant[1] && (bank1 == bank_t'(b));
    assign refr_hit = refr_grant && (refr_bank == bank_t'(b));

    // Port 0 drives the bank whenever it holds the grant
    bank_ram bank_i (
      .clk     (clk),
      .en      (hit0 || hit1),
      .we      (hit0 ? p0_we : p1_we),
      .row     (hit0 ? row0 : row1),
      .din     (hit0 ? p0_dat_w : p1_dat_w),
      .refresh (refr_hit),
      .dout    (bank_dout[b])
    );
  end

  // The bank that served each port is needed one cycle later, in the ack cycle
  always_ff @(posedge clk) begin
    if (grant[0]) begin
      sel0 <= bank0;
    end
    if (grant[1]) begin
      sel1 <= bank1;
    end
  end

  assign p0_dat_r = bank_dout[sel0];
  assign p1_dat_r = bank_dout[sel1];

endmodule

// ==== bank_arbiter.sv ====
`timescale 1ns/1ps
`include "mp_params.svh"

module bank_arbiter (
  input  logic          clk,
  input  logic          rst,
  input  logic          p0_cyc,
  input  logic          p0_stb,
  input  mp_pkg::addr_t p0_adr,
  input  logic          p1_cyc,
  input  logic          p1_stb,
  input  mp_pkg::addr_t p1_adr,
  input  logic          refr_req,
  input  logic          refr_force,
  input  mp_pkg::bank_t refr_bank,
  output logic [1:0]    grant,
  output logic          refr_grant,
  output logic          p0_ack,
  output logic          p1_ack
);
  import mp_pkg::*;

  bank_t bank0;
  bank_t bank1;
  logic  req0;
  logic  req1;
  logic  blk0;
  logic  blk1;
  logic  refr_busy;

  assign bank0 = p0_adr[`MP_BANK_W-1:0];
  assign bank1 = p1_adr[`MP_BANK_W-1:0];

  // A request seen during its own ack cycle is the one just finished
  assign req0 = p0_cyc && p0_stb && !p0_ack;
  assign req1 = p1_cyc && p1_stb && !p1_ack;

  assign blk0 = refr_force && (bank0 == refr_bank);
  assign blk1 = refr_force && (bank1 == refr_bank);

  always_comb begin
    grant[0] = req0 && !blk0;
    grant[1] = req1 && !blk1 && !(grant[0] && (bank0 == bank1)); // Port 1 yields on a conflict
  end

  // Opportunistic refresh only goes to a bank that no port takes this cycle
  assign refr_busy = (grant[0] && (bank0 == refr_bank)) ||
                     (grant[1] && (bank1 == refr_bank));
  assign refr_grant = refr_req && (refr_force || !refr_busy);

  always_ff @(posedge clk) begin
    if (rst) begin
      p0_ack <= 1'b0;
      p1_ack <= 1'b0;
    end else begin
      p0_ack <= grant[0];
      p1_ack <= grant[1];
    end
  end

  // A granted access is acked next cycle and cannot be granted again in it
  a_p0_one_ack: assert property (@(posedge clk) disable iff (rst)
    grant[0] |=> (p0_ack && !grant[0]))
    else $error("bank_arbiter: port 0 granted during its ack");

  a_p1_one_ack: assert property (@(posedge clk) disable iff (rst)
    grant[1] |=> (p1_ack && !grant[1]))
    else $error("bank_arbiter: port 1 granted during its ack");

  a_bank_excl: assert property (@(posedge clk) disable iff (rst)
    !(grant[0] && grant[1] && (bank0 == bank1)))
    else $error("bank_arbiter: both ports granted bank %0d", bank0);

endmodule

// ==== refresh_sched.sv ====
`timescale 1ns/1ps
`include "mp_params.svh"

module refresh_sched (
  input  logic          clk,
  input  logic          rst,
  input  logic          refr,
  input  logic          refr_grant,
  output logic          refr_req,
  output logic          refr_force,
  output mp_pkg::bank_t refr_bank,
  output logic          refr_vld,
  output mp_pkg::bank_t refr_bank_out
);
  import mp_pkg::*;

  typedef logic [`MP_WAIT_W-1:0] wait_t;

  localparam pend_t MAX_PEND  = pend_t'(`MP_REFR_MAX_PEND);
  localparam wait_t WAIT_LAST = wait_t'(`MP_REFR_WAIT - 1);

  refr_state_t state;
  refr_state_t state_nxt;
  pend_t       pend;
  pend_t       pend_nxt;
  wait_t       wait_cnt;
  bank_t       ptr;
  logic        take;

  assign take     = refr && (pend != MAX_PEND);   // Pulses beyond the limit are dropped
  assign pend_nxt = pend + pend_t'(take) - pend_t'(refr_grant);

  assign refr_req   = (state != REFR_IDLE);
  assign refr_force = (state == REFR_FORCE);
  assign refr_bank  = ptr;

  // State follows the pending count, so IDLE means nothing is pending
  always_comb begin
    state_nxt = state;
    case (state)
      REFR_IDLE: if (pend_nxt != '0) state_nxt = REFR_WAIT;
      REFR_WAIT: begin
        if (refr_grant) begin
          state_nxt = (pend_nxt == '0) ? REFR_IDLE : REFR_WAIT;
        end else if (wait_cnt == WAIT_LAST) begin
          state_nxt = REFR_FORCE;
        end
      end
      REFR_FORCE: if (refr_grant) state_nxt = (pend_nxt == '0) ? REFR_IDLE : REFR_WAIT;
      default: state_nxt = REFR_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= REFR_IDLE;
      pend     <= '0;
      wait_cnt <= '0;
      ptr      <= '0;
      refr_vld <= 1'b0;
    end else begin
      state    <= state_nxt;
      pend     <= pend_nxt;
      wait_cnt <= (state == REFR_WAIT && !refr_grant) ? wait_cnt + 1'b1 : '0;
      refr_vld <= refr_grant;
      if (refr_grant) ptr <= ptr + 1'b1;           // Wraps from the last bank to 0
    end
  end

  always_ff @(posedge clk) begin
    if (refr_grant) refr_bank_out <= ptr;
  end

  a_pend_limit: assert property (@(posedge clk) disable iff (rst) pend <= MAX_PEND)
    else $error("refresh_sched: pending count %0d over limit", pend);

endmodule

// ==== mp_top.sv ====
`timescale 1ns/1ps
`include "mp_params.svh"

module mp_top (
  input  logic          clk,
  input  logic          rst,
  input  logic          refr,
  input  logic          p0_cyc,
  input  logic          p0_stb,
  input  logic          p0_we,
  input  mp_pkg::addr_t p0_adr,
  input  mp_pkg::data_t p0_dat_w,
  output mp_pkg::data_t p0_dat_r,
  output logic          p0_ack,
  input  logic          p1_cyc,
  input  logic          p1_stb,
  input  logic          p1_we,
  input  mp_pkg::addr_t p1_adr,
  input  mp_pkg::data_t p1_dat_w,
  output mp_pkg::data_t p1_dat_r,
  output logic          p1_ack,
  output logic          refr_vld,
  output mp_pkg::bank_t refr_bank
);
  import mp_pkg::*;

  logic [1:0] grant;
  logic       refr_grant;
  logic       refr_req;
  logic       refr_force;
  bank_t      refr_target;   // Bank pointer of the pending refresh

  bank_arbiter arb_i (
    .clk        (clk),
    .rst        (rst),
    .p0_cyc     (p0_cyc),
    .p0_stb     (p0_stb),
    .p0_adr     (p0_adr),
    .p1_cyc     (p1_cyc),
    .p1_stb     (p1_stb),
    .p1_adr     (p1_adr),
    .refr_req   (refr_req),
    .refr_force (refr_force),
    .refr_bank  (refr_target),
    .grant      (grant),
    .refr_grant (refr_grant),
    .p0_ack     (p0_ack),
    .p1_ack     (p1_ack)
  );

  refresh_sched sched_i (
    .clk           (clk),
    .rst           (rst),
    .refr          (refr),
    .refr_grant    (refr_grant),
    .refr_req      (refr_req),
    .refr_force    (refr_force),
    .refr_bank     (refr_target),
    .refr_vld      (refr_vld),
    .refr_bank_out (refr_bank)
  );

  bank_array banks_i (
    .clk        (clk),
    .grant      (grant),
    .refr_grant (refr_grant),
    .refr_bank  (refr_target),
    .p0_we      (p0_we),
    .p0_adr     (p0_adr),
    .p0_dat_w   (p0_dat_w),
    .p1_we      (p1_we),
    .p1_adr     (p1_adr),
    .p1_dat_w   (p1_dat_w),
    .p0_dat_r   (p0_dat_r),
    .p1_dat_r   (p1_dat_r)
  );

endmodule

// ==== mp_tb.sv ====
`timescale 1ns/1ps
`include "mp_params.svh"

module mp_tb;
  import mp_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_FIXED  = 23;
  localparam int NUM_RAND   = 24;
  localparam int NUM_TESTS  = NUM_FIXED + NUM_RAND;
  localparam logic [31:0] SEED = 32'd69083;
  localparam int ACK_LIMIT  = 40;
  localparam int REFR_LIMIT = 20;
  localparam int NUM_WORDS  = `MP_NUM_BANKS * `MP_NUM_ROWS;

  localparam int OP_IDLE  = 0;
  localparam int OP_READ  = 1;
  localparam int OP_WRITE = 2;
  localparam int K_PLAIN  = 0;
  localparam int K_SAME   = 1;   // Both acks in the cycle after the request
  localparam int K_ORDER  = 2;   // Port 0 ack strictly before port 1 ack
  localparam int K_RDEXP  = 3;   // Port 0 read must return the table value

  logic  clk = 1'b0;
  logic  rst = 1'b1;
  logic  refr;
  logic  cyc [2];
  logic  stb [2];
  logic  we [2];
  addr_t adr [2];
  data_t dat_w [2];
  data_t dat_r [2];
  logic  ack [2];
  logic  refr_vld;
  bank_t refr_bank;

  string t_name [NUM_TESTS];
  int    t_kind [NUM_TESTS];
  int    t_op [NUM_TESTS][2];
  addr_t t_adr [NUM_TESTS][2];
  data_t t_dat [NUM_TESTS][2];
  int    t_rep [NUM_TESTS];
  int    t_refr [NUM_TESTS];
  logic  t_ptr [NUM_TESTS];
  data_t t_exp [NUM_TESTS];
  int    n_tests = 0;

  data_t model_mem [NUM_WORDS];
  bit    written [NUM_WORDS];
  logic  busy [2];
  logic  cur_we [2];
  addr_t cur_adr [2];
  data_t cur_dat [2];
  data_t last_rd [2];
  int    ack_cyc [2];
  int    cyc_cnt = 0;
  int    vld_cnt = 0;
  bank_t exp_bank;
  bank_t ham_bank;
  int    err_cnt = 0;
  int    fail_tests = 0;
  string cur_name = "reset";
  logic [31:0] lfsr = SEED;

  mp_top dut_i (
    .clk (clk), .rst (rst), .refr (refr),
    .p0_cyc (cyc[0]), .p0_stb (stb[0]), .p0_we (we[0]), .p0_adr (adr[0]),
    .p0_dat_w (dat_w[0]), .p0_dat_r (dat_r[0]), .p0_ack (ack[0]),
    .p1_cyc (cyc[1]), .p1_stb (stb[1]), .p1_we (we[1]), .p1_adr (adr[1]),
    .p1_dat_w (dat_w[1]), .p1_dat_r (dat_r[1]), .p1_ack (ack[1]),
    .refr_vld (refr_vld), .refr_bank (refr_bank)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cyc_cnt <= cyc_cnt + 1;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  function automatic addr_t make_adr(input row_t r, input bank_t b);
    return {r, b};   // Row high, bank low
  endfunction

  task automatic add_entry(input string name, input int kind,
                           input int op0, input addr_t a0, input data_t d0,
                           input int op1, input addr_t a1, input data_t d1,
                           input int rep, input int nref, input logic ptr, input data_t exp);
    t_name[n_tests] = name;
    t_kind[n_tests] = kind;
    t_op[n_tests][0] = op0;
    t_adr[n_tests][0] = a0;
    t_dat[n_tests][0] = d0;
    t_op[n_tests][1] = op1;
    t_adr[n_tests][1] = a1;
    t_dat[n_tests][1] = d1;
    t_rep[n_tests] = rep;
    t_refr[n_tests] = nref;
    t_ptr[n_tests] = ptr;
    t_exp[n_tests] = exp;
    if (op0 == OP_WRITE) written[a0] = 1'b1;
    if (op1 == OP_WRITE) written[a1] = 1'b1;
    n_tests++;
  endtask

  task automatic build_table();
    addr_t ra [2];
    data_t rd [2];
    int    rop [2];
    row_t  rr;
    bank_t rb;
    for (int b = 0; b < `MP_NUM_BANKS; b++) begin
      add_entry($sformatf("wr_bank%0d", b), K_PLAIN,
                OP_WRITE, make_adr(row_t'(1), bank_t'(b)), 32'h1000_0000 + data_t'(b),
                OP_WRITE, make_adr(row_t'(2), bank_t'(b + 1)), 32'h2000_0000 + data_t'(b),
                1, 0, 1'b0, '0);
    end
    for (int b = 0; b < `MP_NUM_BANKS; b++) begin
      add_entry($sformatf("rd_bank%0d", b), K_PLAIN,
                OP_READ, make_adr(row_t'(1), bank_t'(b)), '0,
                OP_READ, make_adr(row_t'(2), bank_t'(b + 1)), '0, 1, 0, 1'b0, '0);
    end
    add_entry("diff_bank_wr", K_SAME, OP_WRITE, make_adr(row_t'(3), bank_t'(2)), 32'hA5A5_0002,
              OP_WRITE, make_adr(row_t'(3), bank_t'(5)), 32'h5A5A_0005, 1, 0, 1'b0, '0);
    add_entry("diff_bank_rd", K_SAME, OP_READ, make_adr(row_t'(3), bank_t'(2)), '0,
              OP_READ, make_adr(row_t'(3), bank_t'(5)), '0, 1, 0, 1'b0, '0);
    add_entry("same_adr_wr", K_ORDER, OP_WRITE, make_adr(row_t'(4), bank_t'(6)), 32'h0000_00F0,
              OP_WRITE, make_adr(row_t'(4), bank_t'(6)), 32'h0000_00F1, 1, 0, 1'b0, '0);
    add_entry("same_adr_rd", K_RDEXP, OP_READ, make_adr(row_t'(4), bank_t'(6)), '0,
              OP_IDLE, '0, '0, 1, 0, 1'b0, 32'h0000_00F1);
    add_entry("refresh", K_PLAIN, OP_IDLE, '0, '0, OP_IDLE, '0, '0, 1, 3, 1'b0, '0);
    // The bank field of these two is replaced by the refresh pointer at run time
    // Both ports take that bank in turn, so it is never free until the refresh is forced
    add_entry("hammer", K_PLAIN, OP_WRITE, make_adr(row_t'(8), '0), 32'hBEEF_0000,
              OP_WRITE, make_adr(row_t'(16), '0), 32'hCAFE_0000, 8, 1, 1'b1, '0);
    add_entry("hammer_rd", K_PLAIN, OP_READ, make_adr(row_t'(8), '0), '0,
              OP_READ, make_adr(row_t'(16), '0), '0, 8, 0, 1'b1, '0);
    for (int i = 0; i < NUM_RAND; i++) begin
      for (int p = 0; p < 2; p++) begin
        rr = row_t'(take_bits(2));
        rb = bank_t'(take_bits(3));
        ra[p] = make_adr(rr, rb);
        rop[p] = (take_bits(1) == 32'd1) ? OP_READ : OP_WRITE;
        if (rop[p] == OP_READ && !written[ra[p]]) rop[p] = OP_WRITE;
        rd[p] = take_bits(32);
      end
      add_entry("random", K_PLAIN, rop[0], ra[0], rd[0], rop[1], ra[1], rd[1], 1, 0, 1'b0, '0);
    end
  endtask

  // Model update and read check, port 0 first when both ack in one cycle
  task automatic check_ack(input int p);
    addr_t a;
    a = cur_adr[p];
    ack_cyc[p] = cyc_cnt;
    if (!busy[p]) begin
      $display("port %0d acked with no request in %s", p, cur_name);
      err_cnt++;
    end else if (cur_we[p]) begin
      model_mem[a] = cur_dat[p];
    end else begin
      last_rd[p] = dat_r[p];
      if (dat_r[p] !== model_mem[a]) begin
        $display("ERR %s p%0d adr %h: expected %h, actual %h",
                 cur_name, p, a, model_mem[a], dat_r[p]);
        err_cnt++;
      end
    end
  endtask

  always @(negedge clk) begin
    if (rst === 1'b0) begin
      for (int p = 0; p < 2; p++) begin
        if (ack[p] === 1'b1) check_ack(p);
      end
      if (refr_vld === 1'b1) begin
        if (refr_bank !== exp_bank) begin
          $display("ERR %s refr_bank: expected %0d, actual %0d", cur_name, exp_bank, refr_bank);
          err_cnt++;
        end
        exp_bank = exp_bank + bank_t'(1);
        vld_cnt++;
      end
    end
  end

  task automatic access(input int p, input logic wr, input addr_t a, input data_t d);
    int waited;
    cyc[p] <= 1'b1;
    stb[p] <= 1'b1;
    we[p] <= wr;
    adr[p] <= a;
    dat_w[p] <= d;
    cur_we[p] = wr;
    cur_adr[p] = a;
    cur_dat[p] = d;
    busy[p] = 1'b1;
    waited = 0;
    @(negedge clk);
    while (ack[p] !== 1'b1 && waited < ACK_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (ack[p] !== 1'b1) begin
      $display("no ack on port %0d within %0d cycles in %s", p, ACK_LIMIT, cur_name);
      err_cnt++;
    end
    @(posedge clk);
    cyc[p] <= 1'b0;   // A following access overrides this in the same step
    stb[p] <= 1'b0;
    busy[p] = 1'b0;
  endtask

  task automatic run_port(input int p, input int op, input addr_t a, input data_t d,
                          input int rep);
    if (op != OP_IDLE) begin
      for (int k = 0; k < rep; k++) begin
        access(p, op == OP_WRITE,
               make_adr(a[`MP_ADDR_W-1:`MP_BANK_W] + row_t'(k), a[`MP_BANK_W-1:0]),
               d + data_t'(k));
      end
    end
  endtask

  task automatic send_refr(input int n);
    for (int k = 0; k < n; k++) begin
      refr <= 1'b1;
      @(posedge clk);
    end
    refr <= 1'b0;
  endtask

  task automatic run_test(input int i);
    addr_t a0;
    addr_t a1;
    int    t0;
    int    waited;
    int    errs_before;
    cur_name = t_name[i];
    errs_before = err_cnt;
    vld_cnt = 0;
    if (t_refr[i] > 0) ham_bank = exp_bank;
    a0 = t_adr[i][0];
    a1 = t_adr[i][1];
    if (t_ptr[i]) a0 = make_adr(a0[`MP_ADDR_W-1:`MP_BANK_W], ham_bank);
    if (t_ptr[i]) a1 = make_adr(a1[`MP_ADDR_W-1:`MP_BANK_W], ham_bank);
    t0 = cyc_cnt;   // The request cycle is t0 + 1 and an immediate ack is t0 + 2
    fork
      run_port(0, t_op[i][0], a0, t_dat[i][0], t_rep[i]);
      run_port(1, t_op[i][1], a1, t_dat[i][1], t_rep[i]);
      send_refr(t_refr[i]);
    join
    if (t_ptr[i] && vld_cnt < t_refr[i]) begin
      $display("%s: refresh of bank %0d was not forced while the ports held it",
               cur_name, ham_bank);
      err_cnt++;
    end
    if (t_refr[i] > 0) begin
      waited = 0;
      while (vld_cnt < t_refr[i] && waited < REFR_LIMIT) begin
        @(posedge clk);
        waited++;
      end
      repeat (4) @(posedge clk);   // Room for a stray extra refr_vld
    end
    if (t_kind[i] == K_SAME) begin
      if (ack_cyc[0] != t0 + 2 || ack_cyc[1] != t0 + 2) begin
        $display("ERR %s ack cycle: expected %0d, actual p0 %0d p1 %0d",
                 cur_name, t0 + 2, ack_cyc[0], ack_cyc[1]);
        err_cnt++;
      end
    end
    if (t_kind[i] == K_ORDER && ack_cyc[0] >= ack_cyc[1]) begin
      $display("%s: port 0 was not acked before port 1", cur_name);
      err_cnt++;
    end
    if (t_kind[i] == K_RDEXP && last_rd[0] !== t_exp[i]) begin
      $display("ERR %s: expected %h, actual %h", cur_name, t_exp[i], last_rd[0]);
      err_cnt++;
    end
    if (vld_cnt != t_refr[i]) begin
      $display("ERR %s refr_vld count: expected %0d, actual %0d", cur_name, t_refr[i], vld_cnt);
      err_cnt++;
    end
    if (err_cnt != errs_before) fail_tests++;
    $display("test %0d %s: %s", i, cur_name, (err_cnt == errs_before) ? "ok" : "failed");
  endtask

  initial begin
    refr = 1'b0;
    for (int p = 0; p < 2; p++) begin
      cyc[p] = 1'b0;
      stb[p] = 1'b0;
      we[p] = 1'b0;
      adr[p] = '0;
      dat_w[p] = '0;
      busy[p] = 1'b0;
      ack_cyc[p] = 0;
    end
    exp_bank = '0;
    ham_bank = '0;
    build_table();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (ack[0] !== 1'b0 || ack[1] !== 1'b0 || refr_vld !== 1'b0) begin
      $display("acks or refr_vld are not low after reset");
      err_cnt++;
    end
    @(posedge clk);
    for (int i = 0; i < n_tests; i++) run_test(i);
    $display("tests %0d, failed %0d, errors %0d", n_tests, fail_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(NUM_TESTS * 20 * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", NUM_TESTS * 20);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+.
mp_pkg.sv
bank_ram.sv
bank_array.sv
bank_arbiter.sv
refresh_sched.sv
mp_top.sv
mp_tb.sv

// ==== Makefile ====
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= mp_tb
FILELIST ?= src.f
BUILD    ?= obj_dir
LOG      ?= sim.log
PASS_MSG := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
